// ==== common/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and address width.
`define CORE_XLEN 32

// first fetch address.
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== common/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef enum logic {
        ms_idle,
        ms_done
    } mem_state_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           instr;
        logic [`CORE_XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] op_a;
        logic [`CORE_XLEN-1:0] op_b;
        logic [`CORE_XLEN-1:0] imm;
        logic [`CORE_XLEN-1:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] result;
        logic [`CORE_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] result;
    } mem_wb_t;

endpackage

// ==== common/wb_if.sv ====
`include "core_config.svh"

interface wb_if;

    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`CORE_XLEN-1:0] adr;
    logic [`CORE_XLEN-1:0] dat_w;
    logic [`CORE_XLEN-1:0] dat_r;
    logic                  ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== flist.f ====
+incdir+common
common/core_pkg.sv
common/wb_if.sv
pipeline/stage_fetch.sv
pipeline/stage_decode.sv
pipeline/stage_execute.sv
pipeline/stage_memory.sv
pipeline/hazard_unit.sv
verilog/core.sv
verif/core_tb_clock.sv
verif/core_properties.sv
verif/core_tb.sv

// ==== pipeline/hazard_unit.sv ====
module hazard_unit (
    input  core_pkg::if_id_t   if_id,
    input  core_pkg::id_ex_t   id_ex,
    input  core_pkg::ex_mem_t  ex_mem,
    input  core_pkg::mem_wb_t  mem_wb,
    input  logic               branch_taken,
    input  logic               busy,
    output core_pkg::fwd_sel_t fwd_a,
    output core_pkg::fwd_sel_t fwd_b,
    output logic               stall_front,
    output logic               flush,
    output logic               freeze
);

    import core_pkg::*;

    logic load_use;

    // the memory stage holds the newer producer, so it wins.
    function automatic fwd_sel_t pick(input logic [4:0] src);
        if (src == 5'd0)
            return fwd_reg;
        else if (ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.rd == src))
            return fwd_mem;
        else if (mem_wb.valid && mem_wb.reg_write && (mem_wb.rd == src))
            return fwd_wb;
        else
            return fwd_reg;
    endfunction

    assign fwd_a = pick(id_ex.rs);
    assign fwd_b = pick(id_ex.rt);

    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && if_id.valid &&
                      (id_ex.rd != 5'd0) &&
                      ((id_ex.rd == if_id.instr[25:21]) || (id_ex.rd == if_id.instr[20:16]));

    assign freeze      = busy;
    assign flush       = branch_taken && !busy;
    assign stall_front = load_use && !busy && !branch_taken;

endmodule

// ==== pipeline/stage_decode.sv ====
`include "core_config.svh"

module stage_decode (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::if_id_t   if_id,
    input  core_pkg::mem_wb_t  mem_wb,
    input  logic               stall_front,
    input  logic               freeze,
    input  logic               flush,
    output core_pkg::id_ex_t   id_ex
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] regs [32];
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            dest;
    logic [`CORE_XLEN-1:0] imm;
    ctrl_t                 ctrl;
    logic                  known;
    logic                  wb_write;

    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign imm      = {{(`CORE_XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};
    assign wb_write = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != 5'd0);

    // write-through so a retiring result is seen by the same-cycle read.
    function automatic logic [`CORE_XLEN-1:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        else if (wb_write && (mem_wb.rd == idx))
            return mem_wb.result;
        else
            return regs[idx];
    endfunction

    always_comb begin
        ctrl  = '0;
        known = 1'b1;
        dest  = 5'd0;
        case (if_id.instr[31:26])
            op_special: begin
                ctrl.reg_write = 1'b1;
                dest           = if_id.instr[15:11];
                case (if_id.instr[5:0])
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    default: known       = 1'b0;
                endcase
            end
            op_addiu: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                dest           = rt;
            end
            op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                dest           = rt;
            end
            op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_beq: begin
                ctrl.alu_op = alu_sub;
                ctrl.branch = 1'b1;
            end
            default: known = 1'b0;   // treated as a no-op.
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_write)
            regs[mem_wb.rd] <= mem_wb.result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (!freeze) begin
            if (flush || stall_front) begin
                id_ex.valid <= 1'b0;   // bubble into execute.
            end else begin
                id_ex.valid <= if_id.valid && known;
                id_ex.ctrl  <= ctrl;
                id_ex.rs    <= rs;
                id_ex.rt    <= rt;
                id_ex.rd    <= dest;
                id_ex.op_a  <= read_reg(rs);
                id_ex.op_b  <= read_reg(rt);
                id_ex.imm   <= imm;
                id_ex.pc    <= if_id.pc;
            end
        end
    end

endmodule

// ==== pipeline/stage_execute.sv ====
`include "core_config.svh"

module stage_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::id_ex_t      id_ex,
    input  core_pkg::fwd_sel_t    fwd_a,
    input  core_pkg::fwd_sel_t    fwd_b,
    input  logic [`CORE_XLEN-1:0] ex_mem_fwd,
    input  logic [`CORE_XLEN-1:0] wb_fwd,
    input  logic                  freeze,
    output core_pkg::ex_mem_t     ex_mem,
    output logic                  branch_taken,
    output logic [`CORE_XLEN-1:0] branch_target
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] src_a;
    logic [`CORE_XLEN-1:0] src_b;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] result;

    function automatic logic [`CORE_XLEN-1:0] operand(input fwd_sel_t sel,
                                                      input logic [`CORE_XLEN-1:0] reg_val);
        case (sel)
            fwd_mem: return ex_mem_fwd;
            fwd_wb:  return wb_fwd;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = operand(fwd_a, id_ex.op_a);
    assign src_b = operand(fwd_b, id_ex.op_b);
    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : src_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: result = src_a - alu_b;
            alu_and: result = src_a & alu_b;
            alu_or:  result = src_a | alu_b;
            alu_slt: result = {{(`CORE_XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            default: result = src_a + alu_b;
        endcase
    end

    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch && (src_a == src_b);
    assign branch_target = id_ex.pc + `CORE_XLEN'd4 + {id_ex.imm[`CORE_XLEN-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (!freeze) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= result;
            ex_mem.store_data <= src_b;   // rt value after forwarding.
        end
    end

endmodule

// ==== pipeline/stage_fetch.sv ====
`include "core_config.svh"

module stage_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_front,
    input  logic                  freeze,
    input  logic                  flush,
    input  logic                  branch_taken,
    input  logic [`CORE_XLEN-1:0] branch_target,
    output logic [`CORE_XLEN-1:0] iaddr,
    input  logic [31:0]           idata,
    output core_pkg::if_id_t      if_id
);

    logic [`CORE_XLEN-1:0] pc;

    assign iaddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= `CORE_RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!freeze) begin
            if (branch_taken)
                pc <= branch_target;   // redirect from execute.
            else if (!stall_front)
                pc <= pc + `CORE_XLEN'd4;

            if (flush) begin
                if_id.valid <= 1'b0;   // younger fetch is squashed.
            end else if (!stall_front) begin
                if_id.valid <= 1'b1;
                if_id.instr <= idata;
                if_id.pc    <= pc;
            end
        end
    end

endmodule

// ==== pipeline/stage_memory.sv ====
`include "core_config.svh"

module stage_memory (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::ex_mem_t ex_mem,
    wb_if.master              bus,
    output logic              busy,
    output core_pkg::mem_wb_t mem_wb
);

    import core_pkg::*;

    mem_state_t            state;
    logic [`CORE_XLEN-1:0] load_data;
    logic                  is_mem;

    assign is_mem = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

    // request stays up until ack, then one idle cycle.
    assign bus.cyc   = is_mem && (state == ms_idle);
    assign bus.stb   = bus.cyc;
    assign bus.we    = bus.cyc && ex_mem.ctrl.mem_write;
    assign bus.adr   = ex_mem.result;
    assign bus.dat_w = ex_mem.store_data;
    assign busy      = is_mem && (state != ms_done);

    always_ff @(posedge clk) begin
        if (reset)
            state <= ms_idle;
        else if (state == ms_done)
            state <= ms_idle;
        else if (bus.cyc && bus.ack)
            state <= ms_done;
    end

    always_ff @(posedge clk) begin
        if (bus.cyc && bus.ack)
            load_data <= bus.dat_r;   // captured at ack.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else if (!busy) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.result    <= ex_mem.ctrl.mem_read ? load_data : ex_mem.result;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module core_tb
output=$(./obj_dir/Vcore_tb 2>&1) || true
echo "$output"
echo "$output" | grep -q -F -x '** PASS **'

// ==== verif/core_properties.sv ====
`include "core_config.svh"

module core_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  cyc,
    input logic                  stb,
    input logic                  we,
    input logic [`CORE_XLEN-1:0] adr,
    input logic                  ack,
    input logic                  freeze,
    input core_pkg::mem_wb_t     mem_wb
);

    int failures = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else begin
            failures++;
            $error("stb high without cyc");
        end

    // a waiting request keeps its address and direction.
    request_held: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we)))
        else begin
            failures++;
            $error("request changed before ack");
        end

    stb_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
        (stb && ack) |=> !stb)
        else begin
            failures++;
            $error("stb still high after ack");
        end

    no_retire_in_freeze: assert property (@(posedge clk) disable iff (reset)
        freeze |=> $stable(mem_wb))
        else begin
            failures++;
            $error("write-back register changed during freeze");
        end

endmodule

bind core core_properties props (
    .clk(clk), .reset(reset),
    .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .ack(wb_ack),
    .freeze(freeze), .mem_wb(mem_wb)
);

// ==== verif/core_tb.sv ====
`include "core_config.svh"

module core_tb;

    typedef enum logic [1:0] {
        acc_none,
        acc_store,
        acc_load
    } access_t;

    localparam logic [5:0] opc_addiu = 6'h09;
    localparam logic [5:0] opc_lw    = 6'h23;
    localparam logic [5:0] opc_sw    = 6'h2b;
    localparam logic [5:0] opc_beq   = 6'h04;
    localparam logic [5:0] fn_addu   = 6'h21;
    localparam logic [5:0] fn_subu   = 6'h23;
    localparam logic [5:0] fn_and    = 6'h24;
    localparam logic [5:0] fn_or     = 6'h25;
    localparam logic [5:0] fn_slt    = 6'h2a;

    logic                  clk;
    logic                  reset;
    logic [`CORE_XLEN-1:0] iaddr;
    logic [31:0]           idata;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`CORE_XLEN-1:0] wb_adr;
    logic [`CORE_XLEN-1:0] wb_dat_w;
    logic [`CORE_XLEN-1:0] wb_dat_r;
    logic                  wb_ack;

    logic [31:0]           prog_word [$];
    access_t               prog_kind [$];
    logic [`CORE_XLEN-1:0] prog_addr [$];
    logic [`CORE_XLEN-1:0] prog_data [$];
    logic                  exp_we [$];
    logic [`CORE_XLEN-1:0] exp_addr [$];
    logic [`CORE_XLEN-1:0] exp_data [$];
    logic [31:0]           imem [64];
    logic [`CORE_XLEN-1:0] dmem [logic [`CORE_XLEN-1:0]];
    int                    seen;
    int                    cycle_limit;
    logic                  pending;
    int unsigned           wait_left;

    core_tb_clock clock_gen (.clk(clk));

    core UUT (
        .clk(clk), .reset(reset), .iaddr(iaddr), .idata(idata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rd,
                                          input int rs, input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt,
                                          input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // untouched words mix every address bit.
    function automatic logic [`CORE_XLEN-1:0] fill_word(input logic [`CORE_XLEN-1:0] adr);
        return ~adr ^ {adr[15:0], adr[31:16]};
    endfunction

    function automatic logic [`CORE_XLEN-1:0] read_word(input logic [`CORE_XLEN-1:0] adr);
        if (dmem.exists(adr))
            return dmem[adr];
        else
            return fill_word(adr);
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] want);
        if (got !== want)
            stop_with_failure($sformatf("Mismatch wb_adr: got %h, expected %h", got, want));
    endtask

    task automatic check_data(input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] want);
        if (got !== want)
            stop_with_failure($sformatf("Mismatch wb_dat_w: got %h, expected %h", got, want));
    endtask

    task automatic check_we(input logic got, input logic want);
        if (got !== want)
            stop_with_failure($sformatf("Mismatch wb_we: got %h, expected %h", got, want));
    endtask

    task automatic add_row(input logic [31:0] word, input access_t kind,
                           input logic [`CORE_XLEN-1:0] addr,
                           input logic [`CORE_XLEN-1:0] data);
        prog_word.push_back(word);
        prog_kind.push_back(kind);
        prog_addr.push_back(addr);
        prog_data.push_back(data);
    endtask

    // r1 = 0x10, r2 = -3, r3 = 0x17 hold through the program.
    task automatic build_program();
        add_row(enc_i(opc_addiu, 1, 0, 16'h0010), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_addiu, 2, 0, 16'hfffd), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 2, 1, 0), acc_store, 32'h10, 32'hffff_fffd);
        add_row(enc_i(opc_addiu, 3, 1, 7), acc_none, 32'h0, 32'h0);
        add_row(enc_r(fn_addu, 4, 1, 3), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 4, 1, 4), acc_store, 32'h14, 32'h27);
        add_row(enc_r(fn_subu, 5, 1, 3), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 5, 1, 8), acc_store, 32'h18, 32'hffff_fff9);
        add_row(enc_r(fn_and, 6, 2, 3), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 6, 1, 12), acc_store, 32'h1c, 32'h15);
        add_row(enc_r(fn_or, 7, 3, 4), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 7, 1, 16), acc_store, 32'h20, 32'h37);
        add_row(enc_r(fn_slt, 8, 2, 1), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 8, 1, 20), acc_store, 32'h24, 32'h1);
        add_row(enc_r(fn_slt, 9, 1, 2), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 9, 1, 24), acc_store, 32'h28, 32'h0);
        add_row(enc_i(opc_lw, 10, 0, 16'h0040), acc_load, 32'h40, 32'h0);
        add_row(enc_r(fn_addu, 11, 10, 3), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 11, 1, 28), acc_store, 32'h2c, fill_word(32'h40) + 32'h17);
        add_row(enc_i(opc_addiu, 0, 0, 16'h0055), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 0, 1, 32), acc_store, 32'h30, 32'h0);
        add_row(enc_i(opc_beq, 1, 1, 2), acc_none, 32'h0, 32'h0);   // taken.
        add_row(enc_i(opc_sw, 3, 1, 36), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_sw, 4, 1, 40), acc_none, 32'h0, 32'h0);
        add_row(enc_i(opc_beq, 2, 1, 1), acc_none, 32'h0, 32'h0);   // not taken.
        add_row(enc_i(opc_sw, 3, 1, 44), acc_store, 32'h3c, 32'h17);
        add_row(enc_i(opc_sw, 5, 1, 48), acc_store, 32'h40, 32'hffff_fff9);
    endtask

    task automatic serve_access();
        if (seen >= exp_we.size()) begin
            stop_with_failure($sformatf("unexpected bus access at address %h", wb_adr));
        end else begin
            check_we(wb_we, exp_we[seen]);
            check_addr(wb_adr, exp_addr[seen]);
            if (wb_we) begin
                check_data(wb_dat_w, exp_data[seen]);
                dmem[wb_adr] = wb_dat_w;
            end else begin
                wb_dat_r = read_word(wb_adr);
            end
            wb_ack = 1'b1;
            seen++;
        end
    endtask

    // instruction and data models run on the falling edge.
    always @(negedge clk) begin
        if (iaddr < `CORE_XLEN'd256)
            idata = imem[iaddr[7:2]];
        else
            idata = 32'h0;
        if (reset) begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack  = 1'b0;   // single-cycle ack.
            pending = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0)
                serve_access();
            else
                wait_left--;
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk);
        stop_with_failure($sformatf("timeout: %0d of %0d bus accesses seen after %0d cycles",
                                    seen, exp_we.size(), cycle_limit));
    end

    initial begin
        void'($urandom(32'hf3c3));
        reset     = 1'b1;
        idata     = 32'h0;
        wb_dat_r  = '0;
        wb_ack    = 1'b0;
        seen      = 0;
        pending   = 1'b0;
        wait_left = 0;
        build_program();
        foreach (imem[i])
            imem[i] = 32'h0;   // zero words decode as no-ops.
        for (int i = 0; i < prog_word.size(); i++) begin
            imem[i] = prog_word[i];
            if (prog_kind[i] != acc_none) begin
                exp_we.push_back(prog_kind[i] == acc_store);
                exp_addr.push_back(prog_addr[i]);
                exp_data.push_back(prog_data[i]);
            end
        end
        cycle_limit = prog_word.size() * 6 + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (seen < exp_we.size())
            @(posedge clk);
        repeat (8) @(posedge clk);   // room for a stray access.
        if (UUT.props.failures == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d bus or pipeline assertions failed",
                                        UUT.props.failures));
        end
    end

endmodule

// ==== verif/core_tb_clock.sv ====
module core_tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #10 clk = ~clk;   // period of 20.

endmodule

// ==== verilog/core.sv ====
`include "core_config.svh"

module core (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`CORE_XLEN-1:0] iaddr,
    input  logic [31:0]           idata,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [`CORE_XLEN-1:0] wb_adr,
    output logic [`CORE_XLEN-1:0] wb_dat_w,
    input  logic [`CORE_XLEN-1:0] wb_dat_r,
    input  logic                  wb_ack
);

    import core_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;
    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    logic                  stall_front;
    logic                  flush;
    logic                  freeze;
    logic                  busy;
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] branch_target;

    wb_if data_bus ();

    assign wb_cyc         = data_bus.cyc;
    assign wb_stb         = data_bus.stb;
    assign wb_we          = data_bus.we;
    assign wb_adr         = data_bus.adr;
    assign wb_dat_w       = data_bus.dat_w;
    assign data_bus.dat_r = wb_dat_r;
    assign data_bus.ack   = wb_ack;

    stage_fetch unit_fetch (
        .clk(clk), .reset(reset),
        .stall_front(stall_front), .freeze(freeze), .flush(flush),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .iaddr(iaddr), .idata(idata), .if_id(if_id)
    );

    // write-back is the register file port inside decode.
    stage_decode unit_decode (
        .clk(clk), .reset(reset),
        .if_id(if_id), .mem_wb(mem_wb),
        .stall_front(stall_front), .freeze(freeze), .flush(flush),
        .id_ex(id_ex)
    );

    stage_execute unit_execute (
        .clk(clk), .reset(reset),
        .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .ex_mem_fwd(ex_mem.result), .wb_fwd(mem_wb.result),
        .freeze(freeze), .ex_mem(ex_mem),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    stage_memory unit_memory (
        .clk(clk), .reset(reset),
        .ex_mem(ex_mem), .bus(data_bus.master),
        .busy(busy), .mem_wb(mem_wb)
    );

    hazard_unit unit_hazard (
        .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .branch_taken(branch_taken), .busy(busy),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall_front(stall_front), .flush(flush), .freeze(freeze)
    );

endmodule
